// ==== hdl/adc_pkg.sv ====
// Sizes are fixed at four 16-bit signed channels; gains are unsigned Q8.8 and results clip at +/-32767
package adc_pkg;

    // Sample path
    localparam int sample_width = 16;
    localparam int n_channels = 4;
    localparam int chan_width = 2;

    // Unsigned Q8.8 gain word
    localparam int gain_width = 16;
    localparam int gain_frac_bits = 8;
    localparam logic [gain_width-1:0] unity_gain = 16'd256;

    // Symmetric saturation limits, -32768 is never produced
    localparam logic signed [sample_width-1:0] sample_max = 16'sd32767;
    localparam logic signed [sample_width-1:0] sample_min = -16'sd32767;

    // Register write port
    localparam int reg_addr_width = 8;
    localparam int reg_data_width = 32;

    // Window and trip words carry low in [31:16], high in [15:0]
    typedef enum logic [reg_addr_width-1:0] {
        addr_offset0     = 8'h00,
        addr_offset1     = 8'h04,
        addr_offset2     = 8'h08,
        addr_offset3     = 8'h0C,
        addr_gain0       = 8'h10,
        addr_gain1       = 8'h14,
        addr_gain2       = 8'h18,
        addr_gain3       = 8'h1C,
        addr_window0     = 8'h20,
        addr_window1     = 8'h24,
        addr_window2     = 8'h28,
        addr_window3     = 8'h2C,
        addr_trip        = 8'h30,
        addr_control     = 8'h34,
        addr_fault_clear = 8'h38
    } reg_addr_e;

    // Control word bit positions
    localparam int ctrl_average_bit = 0;
    localparam int ctrl_sticky_bit = 1;
    localparam int ctrl_denoise_bit = 2;

endpackage

// ==== hdl/adc_config_regs.sv ====
// Write-only register file; no readback, writes to unknown addresses are dropped, effect is one cycle later
module adc_config_regs import adc_pkg::*; (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    reg_write,
    input  logic [reg_addr_width-1:0]               reg_addr,
    input  logic [reg_data_width-1:0]               reg_wdata,
    output logic [n_channels-1:0][sample_width-1:0] offset,
    output logic [n_channels-1:0][gain_width-1:0]   gain,
    output logic [n_channels-1:0][sample_width-1:0] window_low,
    output logic [n_channels-1:0][sample_width-1:0] window_high,
    output logic signed [sample_width-1:0]          trip_low,
    output logic signed [sample_width-1:0]          trip_high,
    output logic                                    average_en,
    output logic                                    sticky_en,
    output logic                                    denoise_en,
    output logic                                    fault_clear
);

    // Channel index sits in the word address bits of each group
    logic [chan_width-1:0] idx;

    assign idx = reg_addr[chan_width+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            offset      <= '0;
            gain        <= {n_channels{unity_gain}};
            window_low  <= {n_channels{sample_min}};
            window_high <= {n_channels{sample_max}};
            trip_low    <= sample_min;
            trip_high   <= sample_max;
            average_en  <= 1'b0;
            sticky_en   <= 1'b0;
            denoise_en  <= 1'b0;
            fault_clear <= 1'b0;
        end else begin
            fault_clear <= 1'b0;
            if (reg_write) begin
                case (reg_addr_e'(reg_addr))
                    addr_offset0, addr_offset1, addr_offset2, addr_offset3: begin
                        offset[idx] <= reg_wdata[sample_width-1:0];
                    end
                    addr_gain0, addr_gain1, addr_gain2, addr_gain3: begin
                        gain[idx] <= reg_wdata[gain_width-1:0];
                    end
                    addr_window0, addr_window1, addr_window2, addr_window3: begin
                        window_low[idx]  <= reg_wdata[reg_data_width-1:sample_width];
                        window_high[idx] <= reg_wdata[sample_width-1:0];
                    end
                    addr_trip: begin
                        trip_low  <= reg_wdata[reg_data_width-1:sample_width];
                        trip_high <= reg_wdata[sample_width-1:0];
                    end
                    addr_control: begin
                        average_en <= reg_wdata[ctrl_average_bit];
                        sticky_en  <= reg_wdata[ctrl_sticky_bit];
                        denoise_en <= reg_wdata[ctrl_denoise_bit];
                    end
                    // Strobe only, nothing is stored
                    addr_fault_clear: begin
                        fault_clear <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // An unknown strobe would corrupt settings silently
    a_write_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(reg_write));

endmodule

// ==== hdl/adc_calibration.sv ====
// One registered stage; result is (sample + offset) * gain >>> 8 clipped to +/-32767, no back-pressure
module adc_calibration import adc_pkg::*; (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    in_valid,
    input  logic [chan_width-1:0]                   in_channel,
    input  logic signed [sample_width-1:0]          in_data,
    input  logic [n_channels-1:0][sample_width-1:0] offset,
    input  logic [n_channels-1:0][gain_width-1:0]   gain,
    output logic                                    cal_valid,
    output logic [chan_width-1:0]                   cal_channel,
    output logic signed [sample_width-1:0]          cal_data
);

    logic signed [sample_width-1:0]          sel_offset;
    logic [gain_width-1:0]                   sel_gain;
    // One extra bit so the offset add cannot wrap
    logic signed [sample_width:0]            sum;
    logic signed [sample_width+gain_width+1:0] product;
    logic signed [sample_width+gain_width+1:0] scaled;
    logic signed [sample_width-1:0]          sat;

    always_comb begin
        sel_offset = $signed(offset[in_channel]);
        sel_gain   = gain[in_channel];
        sum        = (sample_width+1)'(in_data) + (sample_width+1)'(sel_offset);
        // Gain is unsigned so it is zero-extended before the signed multiply
        product    = (sample_width+gain_width+2)'(sum)
                   * (sample_width+gain_width+2)'($signed({1'b0, sel_gain}));
        scaled     = product >>> gain_frac_bits;
        if (scaled > (sample_width+gain_width+2)'(sample_max)) begin
            sat = sample_max;
        end else if (scaled < (sample_width+gain_width+2)'(sample_min)) begin
            sat = sample_min;
        end else begin
            sat = scaled[sample_width-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cal_valid <= 1'b0;
        end else begin
            cal_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        cal_channel <= in_channel;
        cal_data    <= sat;
    end

    // Symmetric clipping keeps the most negative code out of the stream
    a_no_min_code: assert property (@(posedge clk) disable iff (reset)
        cal_valid |-> (cal_data >= sample_min));

endmodule

// ==== hdl/adc_denoise.sv ====
// Spike rejection per channel; last accepted value starts at 0 and updates on every in-window sample
module adc_denoise import adc_pkg::*; (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    cal_valid,
    input  logic [chan_width-1:0]                   cal_channel,
    input  logic signed [sample_width-1:0]          cal_data,
    input  logic [n_channels-1:0][sample_width-1:0] window_low,
    input  logic [n_channels-1:0][sample_width-1:0] window_high,
    input  logic                                    denoise_en,
    output logic                                    fast_valid,
    output logic [chan_width-1:0]                   fast_channel,
    output logic signed [sample_width-1:0]          fast_data
);

    // Last accepted value per channel
    logic signed [sample_width-1:0] held [n_channels];

    logic signed [sample_width-1:0] low;
    logic signed [sample_width-1:0] high;
    logic signed [sample_width-1:0] held_sel;
    logic                           spike;
    logic signed [sample_width-1:0] next_data;

    always_comb begin
        low       = $signed(window_low[cal_channel]);
        high      = $signed(window_high[cal_channel]);
        held_sel  = held[cal_channel];
        spike     = denoise_en && ((cal_data > high) || (cal_data < low));
        next_data = spike ? held_sel : cal_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fast_valid <= 1'b0;
            for (int ch = 0; ch < n_channels; ch++) begin
                held[ch] <= '0;
            end
        end else begin
            fast_valid <= cal_valid;
            if (cal_valid && !spike) begin
                held[cal_channel] <= cal_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        fast_channel <= cal_channel;
        fast_data    <= next_data;
    end

    // Every output equals the value its channel now holds, spike or not
    a_held_match: assert property (@(posedge clk) disable iff (reset)
        fast_valid |-> (fast_data == held[fast_channel]));

endmodule

// ==== hdl/adc_fault_detector.sv ====
// Single trip window shared by all channels; fault_clear only matters in sticky mode
module adc_fault_detector import adc_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           cal_valid,
    input  logic signed [sample_width-1:0] cal_data,
    input  logic signed [sample_width-1:0] trip_low,
    input  logic signed [sample_width-1:0] trip_high,
    input  logic                           sticky_en,
    input  logic                           fault_clear,
    output logic                           fault
);

    logic trip;

    // Outside the window on either side
    assign trip = cal_valid && ((cal_data > trip_high) || (cal_data < trip_low));

    always_ff @(posedge clk) begin
        if (reset) begin
            fault <= 1'b0;
        end else if (sticky_en) begin
            // A new trip beats a clear in the same cycle
            if (trip) begin
                fault <= 1'b1;
            end else if (fault_clear) begin
                fault <= 1'b0;
            end
        end else if (cal_valid) begin
            // Following mode tracks the latest sample
            fault <= trip;
        end
    end

    // Sticky fault only drops on an explicit clear
    a_sticky_hold: assert property (@(posedge clk) disable iff (reset)
        sticky_en && fault && !fault_clear |=> fault);

endmodule

// ==== hdl/adc_average.sv ====
// Four-sample moving average per channel; history fills from zero so the first three outputs are low
module adc_average import adc_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           fast_valid,
    input  logic [chan_width-1:0]          fast_channel,
    input  logic signed [sample_width-1:0] fast_data,
    input  logic                           average_en,
    output logic                           filtered_valid,
    output logic [chan_width-1:0]          filtered_channel,
    output logic signed [sample_width-1:0] filtered_data
);

    // Previous three values per channel with slot 0 newest
    logic signed [sample_width-1:0] hist [n_channels][3];

    // Two guard bits cover the sum of four terms
    logic signed [sample_width+1:0] sum;
    logic signed [sample_width-1:0] avg;

    always_comb begin
        sum = (sample_width+2)'(fast_data) + (sample_width+2)'(hist[fast_channel][0])
            + (sample_width+2)'(hist[fast_channel][1])
            + (sample_width+2)'(hist[fast_channel][2]);
        // Dropping two LSBs is the arithmetic shift by 2
        avg = sum[sample_width+1:2];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            filtered_valid <= 1'b0;
            for (int ch = 0; ch < n_channels; ch++) begin
                for (int k = 0; k < 3; k++) begin
                    hist[ch][k] <= '0;
                end
            end
        end else begin
            filtered_valid <= fast_valid;
            // History advances even with averaging off
            if (fast_valid) begin
                hist[fast_channel][2] <= hist[fast_channel][1];
                hist[fast_channel][1] <= hist[fast_channel][0];
                hist[fast_channel][0] <= fast_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        filtered_channel <= fast_channel;
        filtered_data    <= average_en ? avg : fast_data;
    end

endmodule

// ==== hdl/adc_processing.sv ====
// Top level; outputs cannot be stalled, fast path is 2 cycles and filtered path 3 cycles after input
module adc_processing import adc_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           reg_write,
    input  logic [reg_addr_width-1:0]      reg_addr,
    input  logic [reg_data_width-1:0]      reg_wdata,
    input  logic                           in_valid,
    input  logic [chan_width-1:0]          in_channel,
    input  logic signed [sample_width-1:0] in_data,
    output logic                           fast_valid,
    output logic [chan_width-1:0]          fast_channel,
    output logic signed [sample_width-1:0] fast_data,
    output logic                           filtered_valid,
    output logic [chan_width-1:0]          filtered_channel,
    output logic signed [sample_width-1:0] filtered_data,
    output logic                           fault
);

    // Settings
    logic [n_channels-1:0][sample_width-1:0] offset;
    logic [n_channels-1:0][gain_width-1:0]   gain;
    logic [n_channels-1:0][sample_width-1:0] window_low;
    logic [n_channels-1:0][sample_width-1:0] window_high;
    logic signed [sample_width-1:0]          trip_low;
    logic signed [sample_width-1:0]          trip_high;
    logic                                    average_en;
    logic                                    sticky_en;
    logic                                    denoise_en;
    logic                                    fault_clear;

    // Calibrated stream
    logic                           cal_valid;
    logic [chan_width-1:0]          cal_channel;
    logic signed [sample_width-1:0] cal_data;

    adc_config_regs u_config_regs (
        .clk         (clk),
        .reset       (reset),
        .reg_write   (reg_write),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .offset      (offset),
        .gain        (gain),
        .window_low  (window_low),
        .window_high (window_high),
        .trip_low    (trip_low),
        .trip_high   (trip_high),
        .average_en  (average_en),
        .sticky_en   (sticky_en),
        .denoise_en  (denoise_en),
        .fault_clear (fault_clear)
    );

    adc_calibration u_calibration (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_channel  (in_channel),
        .in_data     (in_data),
        .offset      (offset),
        .gain        (gain),
        .cal_valid   (cal_valid),
        .cal_channel (cal_channel),
        .cal_data    (cal_data)
    );

    adc_denoise u_denoise (
        .clk          (clk),
        .reset        (reset),
        .cal_valid    (cal_valid),
        .cal_channel  (cal_channel),
        .cal_data     (cal_data),
        .window_low   (window_low),
        .window_high  (window_high),
        .denoise_en   (denoise_en),
        .fast_valid   (fast_valid),
        .fast_channel (fast_channel),
        .fast_data    (fast_data)
    );

    // Checks the calibrated value, before spike rejection
    adc_fault_detector u_fault_detector (
        .clk         (clk),
        .reset       (reset),
        .cal_valid   (cal_valid),
        .cal_data    (cal_data),
        .trip_low    (trip_low),
        .trip_high   (trip_high),
        .sticky_en   (sticky_en),
        .fault_clear (fault_clear),
        .fault       (fault)
    );

    adc_average u_average (
        .clk              (clk),
        .reset            (reset),
        .fast_valid       (fast_valid),
        .fast_channel     (fast_channel),
        .fast_data        (fast_data),
        .average_en       (average_en),
        .filtered_valid   (filtered_valid),
        .filtered_channel (filtered_channel),
        .filtered_data    (filtered_data)
    );

endmodule

// ==== verif/adc_processing_tb.sv ====
// Run from the project root so verif/adc_trace.txt is found; one trace line is applied per clock
module adc_processing_tb
    import adc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic                           clk;
    logic                           reset;
    logic                           reg_write;
    logic [reg_addr_width-1:0]      reg_addr;
    logic [reg_data_width-1:0]      reg_wdata;
    logic                           in_valid;
    logic [chan_width-1:0]          in_channel;
    logic signed [sample_width-1:0] in_data;
    logic                           fast_valid;
    logic [chan_width-1:0]          fast_channel;
    logic signed [sample_width-1:0] fast_data;
    logic                           filtered_valid;
    logic [chan_width-1:0]          filtered_channel;
    logic signed [sample_width-1:0] filtered_data;
    logic                           fault;

    // Expected results in sample order
    int exp_chan_q[$];
    int exp_fast_q[$];
    int exp_filt_q[$];
    int exp_fault_q[$];
    // Falling edge on which each fast result is due
    int exp_due_q[$];
    // Filtered results due one cycle after their fast result
    int due_chan_q[$];
    int due_filt_q[$];

    string trace_lines[$];
    int    limit_ns = 0;
    int    neg_cycles = 0;

    adc_processing u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic signed [31:0] got,
                               input logic signed [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    a;
        int    b;
        int    c;
        int    d;
        int    e;
        int    cycles;
        int    idx;
        bit    seen_end;
        string line;
        string tag;

        reset      = 1'b1;
        reg_write  = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        in_valid   = 1'b0;
        in_channel = '0;
        in_data    = '0;
        seen_end   = 1'b0;
        cycles     = 0;

        fd = $fopen("verif/adc_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open verif/adc_trace.txt, run from the project root");
            $display("Test failures found");
            $fatal(1);
        end
        // Keep the non-comment lines and count the clocks they take
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%s", tag) == 1 && tag.substr(0, 0) != "#") begin
                if (tag == "W") begin
                    n = $sscanf(line, "%s %h %h", tag, a, b) - 3;
                end else if (tag == "S") begin
                    n = $sscanf(line, "%s %d %d %d %d %d", tag, a, b, c, d, e) - 6;
                end else if (tag == "I") begin
                    n = $sscanf(line, "%s %d", tag, a) - 2;
                    cycles += a - 1;
                end else begin
                    n = 0;
                end
                if (n != 0) begin
                    $display("Trace line has missing fields: %s", line);
                    $display("Test failures found");
                    $fatal(1);
                end
                trace_lines.push_back(line);
                cycles += 1;
            end
        end
        $fclose(fd);
        // Reset, trace and a drain margin
        limit_ns = (cycles + 5 + 20) * 10;

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        idx = 0;
        while (!seen_end && idx < trace_lines.size()) begin
            @(posedge clk);
            reg_write <= 1'b0;
            in_valid  <= 1'b0;
            n = $sscanf(trace_lines[idx], "%s", tag);
            if (tag == "W") begin
                n = $sscanf(trace_lines[idx], "%s %h %h", tag, a, b);
                reg_write <= 1'b1;
                reg_addr  <= a[reg_addr_width-1:0];
                reg_wdata <= b;
            end else if (tag == "S") begin
                n = $sscanf(trace_lines[idx], "%s %d %d %d %d %d", tag, a, b, c, d, e);
                in_valid   <= 1'b1;
                in_channel <= a[chan_width-1:0];
                in_data    <= b[sample_width-1:0];
                exp_chan_q.push_back(a);
                exp_fast_q.push_back(c);
                exp_filt_q.push_back(d);
                exp_fault_q.push_back(e);
                // Fast result due on the third falling edge from here
                exp_due_q.push_back(neg_cycles + 3);
            end else if (tag == "I") begin
                // This edge already counts as the first idle cycle
                n = $sscanf(trace_lines[idx], "%s %d", tag, a);
                repeat (a - 1) @(posedge clk);
            end else if (tag == "E") begin
                seen_end = 1'b1;
            end else begin
                $display("Unknown trace line: %s", trace_lines[idx]);
                $display("Test failures found");
                $fatal(1);
            end
            idx++;
        end
        if (!seen_end) begin
            $display("Trace ended without an end marker");
            $display("Test failures found");
            $fatal(1);
        end
        // At most three samples still in flight
        repeat (6) @(negedge clk);
        if (exp_fast_q.size() != 0 || due_filt_q.size() != 0) begin
            $display("Trace finished but %0d expected results never arrived",
                     exp_fast_q.size() + due_filt_q.size());
            $display("Test failures found");
            $fatal(1);
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

    // Outputs are sampled mid-cycle, well away from the driving edge
    always @(negedge clk) begin
        neg_cycles++;
        if (!reset) begin
            if (filtered_valid && due_filt_q.size() == 0) begin
                $display("filtered_valid was raised with no result expected");
                $display("Test failures found");
                $fatal(1);
            end else begin
                // Each filtered result follows its fast result by one cycle
                check_value("filtered_valid", 32'(filtered_valid),
                            32'(due_filt_q.size() != 0));
                if (filtered_valid) begin
                    check_value("filtered_channel", 32'(filtered_channel),
                                due_chan_q.pop_front());
                    check_value("filtered_data", 32'(filtered_data), due_filt_q.pop_front());
                end
            end
            if (fast_valid && exp_fast_q.size() == 0) begin
                $display("fast_valid was raised with no sample expected");
                $display("Test failures found");
                $fatal(1);
            end else begin
                check_value("fast_valid", 32'(fast_valid),
                            32'(exp_due_q.size() != 0 && exp_due_q[0] == neg_cycles));
                if (fast_valid) begin
                    void'(exp_due_q.pop_front());
                    check_value("fast_channel", 32'(fast_channel), exp_chan_q[0]);
                    check_value("fast_data", 32'(fast_data), exp_fast_q.pop_front());
                    check_value("fault", 32'(fault), exp_fault_q.pop_front());
                    due_chan_q.push_back(exp_chan_q.pop_front());
                    due_filt_q.push_back(exp_filt_q.pop_front());
                end
            end
        end
    end

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("Timeout after %0d ns, the trace did not complete", limit_ns);
        $display("Test failures found");
        $fatal(1);
    end

endmodule

// ==== verif/adc_trace.txt ====
# W addr data (hex) | S channel sample fast filtered fault (decimal) | I idle_cycles | E end
# Lines starting with # are comments; one line is applied per clock
# Reset defaults pass samples through
S 0 100 100 100 0
S 1 -200 -200 -200 0
S 2 32767 32767 32767 0
S 3 -5 -5 -5 0
# ch0 offset 10 gain 2.0, ch1 offset -1000 gain 1.5
W 00 0000000A
W 10 00000200
W 04 0000FC18
W 14 00000180
S 0 100 220 220 0
S 1 21000 30000 30000 0
S 1 23000 32767 32767 0
S 1 -23000 -32767 -32767 0
S 1 -1001 -3002 -3002 0
# ch2 window -100 to 100, denoise on
I 4
W 28 FF9C0064
W 34 00000004
S 2 50 50 50 0
S 3 7 7 7 0
S 2 500 50 50 0
S 2 -300 50 50 0
S 3 -9 -9 -9 0
S 2 -80 -80 -80 0
# Averaging on, denoise off, channels interleaved
I 4
W 34 00000001
S 0 30 80 100 0
S 1 1000 0 -751 0
S 2 40 40 15 0
S 3 13 13 1 0
S 0 50 120 130 0
S 1 1400 600 -8793 0
S 2 -40 -40 -8 0
S 3 1003 1003 253 0
# Trip window -1000 to 1000, following then sticky
I 4
W 30 FC1803E8
W 34 00000000
S 3 500 500 500 0
S 3 1500 1500 1500 1
S 3 -200 -200 -200 0
I 2
W 34 00000002
S 3 -1200 -1200 -1200 1
S 3 0 0 0 1
S 3 100 100 100 1
W 38 00000000
I 3
S 3 100 100 100 0
E

// ==== files.f ====
hdl/adc_pkg.sv
hdl/adc_config_regs.sv
hdl/adc_calibration.sv
hdl/adc_denoise.sv
hdl/adc_fault_detector.sv
hdl/adc_average.sv
hdl/adc_processing.sv
verif/adc_processing_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module adc_processing_tb \
    -f files.f -o adc_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/adc_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
